// ==== hw/mc_pkg.sv ====
/*
  Shared widths, field types and constants for the manycore wrapper model.
  The array is fixed at one tile row (y=0) and one cache row (y=1).
  Any x at or beyond the row size is stray and goes to the tie-off.
*/

package mc_pkg;

  // field widths
  localparam int X_CORD_W  = 2;
  localparam int Y_CORD_W  = 1;
  localparam int ADDR_W    = 4;
  localparam int DATA_W    = 32;
  localparam int LOAD_ID_W = 2;

  typedef logic [X_CORD_W-1:0]  x_cord_t;
  typedef logic [Y_CORD_W-1:0]  y_cord_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [LOAD_ID_W-1:0] load_id_t;

  // array shape
  localparam int      NUM_TILES_X = 2;
  localparam int      NUM_CACHE   = 2;
  localparam y_cord_t TILE_Y      = 1'b0;
  localparam y_cord_t CACHE_Y     = 1'b1;

  // words per tile data memory
  localparam int MEM_WORDS = 1 << ADDR_W;

  // loader may have this many requests in flight
  localparam int NUM_CREDITS = 4;

  typedef logic [$clog2(NUM_CREDITS+1)-1:0] credit_t;

  typedef enum logic [0:0] {
    OP_STORE = 1'b0,
    OP_LOAD  = 1'b1
  } mc_op_e;

  typedef enum logic [2:0] {
    ARB_TILE0  = 3'd0,
    ARB_TILE1  = 3'd1,
    ARB_CACHE0 = 3'd2,
    ARB_CACHE1 = 3'd3,
    ARB_STRAY  = 3'd4
  } arb_state_e;

endpackage

// ==== hw/mc_router.sv ====
/*
  One-entry request register with destination decode.
  Offers the held packet to exactly one tile, cache port or the tie-off.
  req_v_i must already be qualified by loader credits.
*/

`timescale 1ns/1ps

module mc_router (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                req_v_i,
  input  mc_pkg::x_cord_t                     req_x_i,
  input  mc_pkg::y_cord_t                     req_y_i,
  input  mc_pkg::mc_op_e                      req_op_i,
  input  mc_pkg::addr_t                       req_addr_i,
  input  mc_pkg::data_t                       req_data_i,
  input  mc_pkg::load_id_t                    req_id_i,
  output logic                                req_ready_o,
  output logic [mc_pkg::NUM_TILES_X-1:0]      tile_v_o,
  output logic [mc_pkg::NUM_CACHE-1:0]        cache_v_o,
  output logic                                stray_v_o,
  input  logic [mc_pkg::NUM_TILES_X-1:0]      tile_ready_i,
  input  logic [mc_pkg::NUM_CACHE-1:0]        cache_ready_i,
  input  logic                                stray_ready_i,
  output mc_pkg::mc_op_e                      out_op_o,
  output mc_pkg::addr_t                       out_addr_o,
  output mc_pkg::data_t                       out_data_o,
  output mc_pkg::load_id_t                    out_id_o
);
  import mc_pkg::*;

  logic                   full_q;
  logic                   accept;
  logic                   drain;
  logic [NUM_TILES_X-1:0] tile_sel_d;
  logic [NUM_TILES_X-1:0] tile_sel_q;
  logic [NUM_CACHE-1:0]   cache_sel_d;
  logic [NUM_CACHE-1:0]   cache_sel_q;
  logic                   stray_sel_d;
  logic                   stray_sel_q;

  // destination decode from coordinates
  always_comb begin
    for (int i = 0; i < NUM_TILES_X; i++) begin
      tile_sel_d[i] = (req_y_i == TILE_Y) && (req_x_i == x_cord_t'(i));
    end
    for (int i = 0; i < NUM_CACHE; i++) begin
      cache_sel_d[i] = (req_y_i == CACHE_Y) && (req_x_i == x_cord_t'(i));
    end
    stray_sel_d = ~(|tile_sel_d) & ~(|cache_sel_d);
  end

  assign tile_v_o  = {NUM_TILES_X{full_q}} & tile_sel_q;
  assign cache_v_o = {NUM_CACHE{full_q}} & cache_sel_q;
  assign stray_v_o = full_q & stray_sel_q;

  assign drain = (|(tile_v_o & tile_ready_i)) | (|(cache_v_o & cache_ready_i)) |
                 (stray_v_o & stray_ready_i);

  // entry can refill in the cycle it drains
  assign req_ready_o = ~full_q | drain;
  assign accept      = req_v_i & req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q      <= 1'b0;
      tile_sel_q  <= '0;
      cache_sel_q <= '0;
      stray_sel_q <= 1'b0;
    end else if (accept) begin
      full_q      <= 1'b1;
      tile_sel_q  <= tile_sel_d;
      cache_sel_q <= cache_sel_d;
      stray_sel_q <= stray_sel_d;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_op_o   <= req_op_i;
      out_addr_o <= req_addr_i;
      out_data_o <= req_data_i;
      out_id_o   <= req_id_i;
    end
  end

endmodule

// ==== hw/mc_tile.sv ====
/*
  Compute tile reduced to its data memory.
  Memory clears on reset. One response is held at a time and
  no request is taken until that response is accepted.
*/

`timescale 1ns/1ps

module mc_tile (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             req_v_i,
  input  mc_pkg::mc_op_e   req_op_i,
  input  mc_pkg::addr_t    req_addr_i,
  input  mc_pkg::data_t    req_data_i,
  input  mc_pkg::load_id_t req_id_i,
  output logic             req_ready_o,
  output logic             resp_v_o,
  output mc_pkg::data_t    resp_data_o,
  output mc_pkg::load_id_t resp_id_o,
  input  logic             resp_ready_i
);
  import mc_pkg::*;

  data_t mem_q [MEM_WORDS];
  logic  req_fire;

  assign req_ready_o = ~resp_v_o;
  assign req_fire    = req_v_i & req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (req_fire && req_op_i == OP_STORE) begin
      mem_q[req_addr_i] <= req_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_v_o <= 1'b0;
    end else if (req_fire) begin
      resp_v_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_o <= 1'b0;
    end
  end

  // stores answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_data_o <= (req_op_i == OP_LOAD) ? mem_q[req_addr_i] : '0;
      resp_id_o   <= req_id_i;
    end
  end

endmodule

// ==== hw/mc_link_tieoff.sv ====
/*
  Sink for requests with no real destination.
  Only the id is kept; the arbiter marks the response as an error.
*/

`timescale 1ns/1ps

module mc_link_tieoff (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             req_v_i,
  input  mc_pkg::load_id_t req_id_i,
  output logic             req_ready_o,
  output logic             resp_v_o,
  output mc_pkg::load_id_t resp_id_o,
  input  logic             resp_ready_i
);
  import mc_pkg::*;

  load_id_t id_q;
  logic     req_fire;

  assign req_ready_o = ~resp_v_o;
  assign req_fire    = req_v_i & req_ready_o;
  assign resp_id_o   = id_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_v_o <= 1'b0;
    end else if (req_fire) begin
      resp_v_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      id_q <= req_id_i;
    end
  end

endmodule

// ==== hw/mc_credit_counter.sv ====
/*
  Loader credit pool, starts full after reset.
  take_i and give_i are transfers, not requests; the caller
  must never give back more credits than were taken.
*/

`timescale 1ns/1ps

module mc_credit_counter (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic take_i,
  input  logic give_i,
  output logic avail_o
);
  import mc_pkg::*;

  credit_t count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= credit_t'(NUM_CREDITS);
    end else begin
      // take and give in one cycle cancel
      unique case ({take_i, give_i})
        2'b10:   count_q <= count_q - credit_t'(1);
        2'b01:   count_q <= count_q + credit_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign avail_o = (count_q != '0);

endmodule

// ==== hw/mc_resp_arbiter.sv ====
/*
  Round-robin response merge toward the loader.
  Grant holds until the granted response transfers, and skips ahead
  when the granted source is idle. Output path is combinational.
*/

`timescale 1ns/1ps

module mc_resp_arbiter (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [mc_pkg::NUM_TILES_X-1:0]        tile_v_i,
  input  mc_pkg::data_t [mc_pkg::NUM_TILES_X-1:0]    tile_data_i,
  input  mc_pkg::load_id_t [mc_pkg::NUM_TILES_X-1:0] tile_id_i,
  output logic [mc_pkg::NUM_TILES_X-1:0]        tile_ready_o,
  input  logic [mc_pkg::NUM_CACHE-1:0]          cache_v_i,
  input  mc_pkg::data_t [mc_pkg::NUM_CACHE-1:0]      cache_data_i,
  input  mc_pkg::load_id_t [mc_pkg::NUM_CACHE-1:0]   cache_id_i,
  output logic [mc_pkg::NUM_CACHE-1:0]          cache_ready_o,
  input  logic                                  stray_v_i,
  input  mc_pkg::load_id_t                      stray_id_i,
  output logic                                  stray_ready_o,
  output logic                                  resp_v_o,
  output mc_pkg::data_t                         resp_data_o,
  output mc_pkg::load_id_t                      resp_id_o,
  output logic                                  resp_err_o,
  input  logic                                  resp_ready_i
);
  import mc_pkg::*;

  arb_state_e state_q;
  arb_state_e state_d;

  // forward only the granted source
  always_comb begin
    resp_v_o      = 1'b0;
    resp_data_o   = '0;
    resp_id_o     = '0;
    resp_err_o    = 1'b0;
    tile_ready_o  = '0;
    cache_ready_o = '0;
    stray_ready_o = 1'b0;
    unique case (state_q)
      ARB_TILE0: begin
        resp_v_o        = tile_v_i[0];
        resp_data_o     = tile_data_i[0];
        resp_id_o       = tile_id_i[0];
        tile_ready_o[0] = resp_ready_i;
      end
      ARB_TILE1: begin
        resp_v_o        = tile_v_i[1];
        resp_data_o     = tile_data_i[1];
        resp_id_o       = tile_id_i[1];
        tile_ready_o[1] = resp_ready_i;
      end
      ARB_CACHE0: begin
        resp_v_o         = cache_v_i[0];
        resp_data_o      = cache_data_i[0];
        resp_id_o        = cache_id_i[0];
        cache_ready_o[0] = resp_ready_i;
      end
      ARB_CACHE1: begin
        resp_v_o         = cache_v_i[1];
        resp_data_o      = cache_data_i[1];
        resp_id_o        = cache_id_i[1];
        cache_ready_o[1] = resp_ready_i;
      end
      ARB_STRAY: begin
        // error response, data stays zero
        resp_v_o      = stray_v_i;
        resp_id_o     = stray_id_i;
        resp_err_o    = 1'b1;
        stray_ready_o = resp_ready_i;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    if (!resp_v_o || resp_ready_i) begin
      unique case (state_q)
        ARB_TILE0:  state_d = ARB_TILE1;
        ARB_TILE1:  state_d = ARB_CACHE0;
        ARB_CACHE0: state_d = ARB_CACHE1;
        ARB_CACHE1: state_d = ARB_STRAY;
        default:    state_d = ARB_TILE0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ARB_TILE0;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hw/mc_wrapper.sv ====
/*
  Two-tile manycore model behind a single loader port.
  Cache ports sit on row CACHE_Y and are modelled outside.
  Cache request payload is shared; only the per-port valid differs.
*/

`timescale 1ns/1ps

module mc_wrapper (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      req_v_i,
  input  mc_pkg::x_cord_t                           req_x_i,
  input  mc_pkg::y_cord_t                           req_y_i,
  input  mc_pkg::mc_op_e                            req_op_i,
  input  mc_pkg::addr_t                             req_addr_i,
  input  mc_pkg::data_t                             req_data_i,
  input  mc_pkg::load_id_t                          req_id_i,
  output logic                                      req_ready_o,
  output logic                                      resp_v_o,
  output mc_pkg::data_t                             resp_data_o,
  output mc_pkg::load_id_t                          resp_id_o,
  output logic                                      resp_err_o,
  input  logic                                      resp_ready_i,
  output logic [mc_pkg::NUM_CACHE-1:0]              cache_req_v_o,
  output mc_pkg::mc_op_e                            cache_req_op_o,
  output mc_pkg::addr_t                             cache_req_addr_o,
  output mc_pkg::data_t                             cache_req_data_o,
  output mc_pkg::load_id_t                          cache_req_id_o,
  input  logic [mc_pkg::NUM_CACHE-1:0]              cache_req_ready_i,
  input  logic [mc_pkg::NUM_CACHE-1:0]              cache_resp_v_i,
  input  mc_pkg::data_t [mc_pkg::NUM_CACHE-1:0]     cache_resp_data_i,
  input  mc_pkg::load_id_t [mc_pkg::NUM_CACHE-1:0]  cache_resp_id_i,
  output logic [mc_pkg::NUM_CACHE-1:0]              cache_resp_ready_o,
  output mc_pkg::x_cord_t [mc_pkg::NUM_CACHE-1:0]   cache_x_o,
  output mc_pkg::y_cord_t [mc_pkg::NUM_CACHE-1:0]   cache_y_o
);
  import mc_pkg::*;

  logic                              credit_avail;
  logic                              rtr_req_v;
  logic                              rtr_req_ready;
  logic [NUM_TILES_X-1:0]            tile_req_v;
  logic [NUM_TILES_X-1:0]            tile_req_ready;
  logic [NUM_TILES_X-1:0]            tile_resp_v;
  data_t [NUM_TILES_X-1:0]           tile_resp_data;
  load_id_t [NUM_TILES_X-1:0]        tile_resp_id;
  logic [NUM_TILES_X-1:0]            tile_resp_ready;
  logic                              stray_req_v;
  logic                              stray_req_ready;
  logic                              stray_resp_v;
  load_id_t                          stray_resp_id;
  logic                              stray_resp_ready;

  // loader sees ready only with a free credit and out of reset
  assign rtr_req_v   = req_v_i & credit_avail;
  assign req_ready_o = arst_n_i & credit_avail & rtr_req_ready;

  mc_credit_counter u_credit (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .take_i   (req_v_i & req_ready_o),
    .give_i   (resp_v_o & resp_ready_i),
    .avail_o  (credit_avail)
  );

  mc_router u_router (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_v_i       (rtr_req_v),
    .req_x_i       (req_x_i),
    .req_y_i       (req_y_i),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .req_id_i      (req_id_i),
    .req_ready_o   (rtr_req_ready),
    .tile_v_o      (tile_req_v),
    .cache_v_o     (cache_req_v_o),
    .stray_v_o     (stray_req_v),
    .tile_ready_i  (tile_req_ready),
    .cache_ready_i (cache_req_ready_i),
    .stray_ready_i (stray_req_ready),
    .out_op_o      (cache_req_op_o),
    .out_addr_o    (cache_req_addr_o),
    .out_data_o    (cache_req_data_o),
    .out_id_o      (cache_req_id_o)
  );

  for (genvar i = 0; i < NUM_TILES_X; i++) begin : g_tile
    mc_tile u_tile (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_v_i      (tile_req_v[i]),
      .req_op_i     (cache_req_op_o),
      .req_addr_i   (cache_req_addr_o),
      .req_data_i   (cache_req_data_o),
      .req_id_i     (cache_req_id_o),
      .req_ready_o  (tile_req_ready[i]),
      .resp_v_o     (tile_resp_v[i]),
      .resp_data_o  (tile_resp_data[i]),
      .resp_id_o    (tile_resp_id[i]),
      .resp_ready_i (tile_resp_ready[i])
    );
  end

  mc_link_tieoff u_tieoff (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_v_i      (stray_req_v),
    .req_id_i     (cache_req_id_o),
    .req_ready_o  (stray_req_ready),
    .resp_v_o     (stray_resp_v),
    .resp_id_o    (stray_resp_id),
    .resp_ready_i (stray_resp_ready)
  );

  mc_resp_arbiter u_arb (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .tile_v_i      (tile_resp_v),
    .tile_data_i   (tile_resp_data),
    .tile_id_i     (tile_resp_id),
    .tile_ready_o  (tile_resp_ready),
    .cache_v_i     (cache_resp_v_i),
    .cache_data_i  (cache_resp_data_i),
    .cache_id_i    (cache_resp_id_i),
    .cache_ready_o (cache_resp_ready_o),
    .stray_v_i     (stray_resp_v),
    .stray_id_i    (stray_resp_id),
    .stray_ready_o (stray_resp_ready),
    .resp_v_o      (resp_v_o),
    .resp_data_o   (resp_data_o),
    .resp_id_o     (resp_id_o),
    .resp_err_o    (resp_err_o),
    .resp_ready_i  (resp_ready_i)
  );

  // south ports: x is the port index, y the cache row
  for (genvar i = 0; i < NUM_CACHE; i++) begin : g_cache_cord
    assign cache_x_o[i] = x_cord_t'(i);
    assign cache_y_o[i] = CACHE_Y;
  end

endmodule

// ==== verification/mc_wrapper_chk.sv ====
/*
  Handshake and tie-off checks bound into every mc_wrapper.
  Outstanding requests are counted from the loader handshakes.
*/

`timescale 1ns/1ps

module mc_wrapper_chk (
  input logic                                    clk_i,
  input logic                                    arst_n_i,
  input logic                                    req_v_i,
  input logic                                    req_ready_o,
  input logic                                    resp_v_o,
  input mc_pkg::data_t                           resp_data_o,
  input mc_pkg::load_id_t                        resp_id_o,
  input logic                                    resp_err_o,
  input logic                                    resp_ready_i,
  input logic [mc_pkg::NUM_CACHE-1:0]            cache_req_v_o,
  input mc_pkg::mc_op_e                          cache_req_op_o,
  input mc_pkg::addr_t                           cache_req_addr_o,
  input mc_pkg::data_t                           cache_req_data_o,
  input mc_pkg::load_id_t                        cache_req_id_o,
  input logic [mc_pkg::NUM_CACHE-1:0]            cache_req_ready_i,
  input mc_pkg::x_cord_t [mc_pkg::NUM_CACHE-1:0] cache_x_o,
  input mc_pkg::y_cord_t [mc_pkg::NUM_CACHE-1:0] cache_y_o
);
  import mc_pkg::*;

  int      fail_cnt = 0;
  credit_t outstanding_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + credit_t'(req_v_i & req_ready_o)
                       - credit_t'(resp_v_o & resp_ready_i);
    end
  end

  a_resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_data_o) &&
      $stable(resp_id_o) && $stable(resp_err_o))
    else begin
      $error("loader response changed before it was accepted");
      fail_cnt++;
    end

  a_cache_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cache_req_v_o & ~cache_req_ready_i) != '0 |=> $stable(cache_req_v_o) &&
      $stable(cache_req_op_o) && $stable(cache_req_addr_o) &&
      $stable(cache_req_data_o) && $stable(cache_req_id_o))
    else begin
      $error("cache request changed before it was accepted");
      fail_cnt++;
    end

  a_credit_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    outstanding_q == credit_t'(NUM_CREDITS) |-> !req_ready_o)
    else begin
      $error("loader ready with every credit outstanding");
      fail_cnt++;
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !req_ready_o && !resp_v_o && cache_req_v_o == '0)
    else begin
      $error("valid or loader ready raised during reset");
      fail_cnt++;
    end

  for (genvar i = 0; i < NUM_CACHE; i++) begin : g_cord
    a_cache_cord: assert property (@(posedge clk_i)
      cache_x_o[i] == x_cord_t'(i) && cache_y_o[i] == CACHE_Y)
      else begin
        $error("cache port coordinates wrong");
        fail_cnt++;
      end
  end

endmodule

bind mc_wrapper mc_wrapper_chk u_chk (.*);

// ==== verification/mc_tb.sv ====
/*
  Testbench for mc_wrapper. Both cache ports are modelled here; each takes
  one request at a time and answers after 0 to 3 cycles.
  Inputs change on the falling edge and outputs are sampled 1 ns later.
  Load ids double as scoreboard keys, so at most four requests are in flight.
*/

`timescale 1ns/1ps

module mc_tb;
  import mc_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int NUM_IDS = 1 << LOAD_ID_W;

  logic                                clk_i;
  logic                                arst_n_i;
  logic                                req_v_i;
  x_cord_t                             req_x_i;
  y_cord_t                             req_y_i;
  mc_op_e                              req_op_i;
  addr_t                               req_addr_i;
  data_t                               req_data_i;
  load_id_t                            req_id_i;
  logic                                req_ready_o;
  logic                                resp_v_o;
  data_t                               resp_data_o;
  load_id_t                            resp_id_o;
  logic                                resp_err_o;
  logic                                resp_ready_i;
  logic [NUM_CACHE-1:0]                cache_req_v_o;
  mc_op_e                              cache_req_op_o;
  addr_t                               cache_req_addr_o;
  data_t                               cache_req_data_o;
  load_id_t                            cache_req_id_o;
  wire  [NUM_CACHE-1:0]                cache_req_ready_i;
  wire  [NUM_CACHE-1:0]                cache_resp_v_i;
  wire  [NUM_CACHE-1:0][DATA_W-1:0]    cache_resp_data_i;
  wire  [NUM_CACHE-1:0][LOAD_ID_W-1:0] cache_resp_id_i;
  logic [NUM_CACHE-1:0]                cache_resp_ready_o;
  x_cord_t [NUM_CACHE-1:0]             cache_x_o;
  y_cord_t [NUM_CACHE-1:0]             cache_y_o;

  // scoreboard, indexed by x, y and addr
  data_t            ref_mem [4][2][MEM_WORDS];
  logic [63:0]      fwd_q [NUM_CACHE][$];
  logic             busy [NUM_IDS];
  data_t            exp_data [NUM_IDS];
  logic             exp_err [NUM_IDS];
  string            test_name;
  int               errors;
  int               checks;
  int               tests;
  int               resp_cnt;
  int               errors0;
  int               checks0;
  int               resp_cnt0;
  logic             hold_resp;
  logic             rand_stall;
  logic             timed_out;
  integer           seed;

  mc_wrapper u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    if (!timed_out) begin
      $display("timeout in test %s while waiting for %s", test_name, what);
    end
    timed_out = 1'b1;
    errors++;
  endtask

  function automatic int free_id();
    for (int i = 0; i < NUM_IDS; i++) begin
      if (!busy[i]) return i;
    end
    return -1;
  endfunction

  function automatic logic any_busy();
    for (int i = 0; i < NUM_IDS; i++) begin
      if (busy[i]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // expected response follows the routing rule, not the DUT
  task automatic expect_resp(input x_cord_t x, input y_cord_t y, input mc_op_e op,
                             input addr_t addr, input data_t data, input load_id_t id);
    busy[id]     = 1'b1;
    exp_err[id]  = 1'b0;
    exp_data[id] = '0;
    if ((y == TILE_Y && x < NUM_TILES_X) || (y == CACHE_Y && x < NUM_CACHE)) begin
      if (op == OP_LOAD) begin
        exp_data[id] = ref_mem[x][y][addr];
      end else begin
        ref_mem[x][y][addr] = data;
      end
      if (y == CACHE_Y) begin
        fwd_q[x].push_back({op, addr, data, id});
      end
    end else begin
      exp_err[id] = 1'b1;
    end
  endtask

  task automatic send_req(input x_cord_t x, input y_cord_t y, input mc_op_e op,
                          input addr_t addr, input data_t data);
    int id;
    int t;
    id = -1;
    t  = 0;
    @(negedge clk_i);
    // ids come back only with their response
    while (id < 0 && !timed_out) begin
      id = free_id();
      if (id < 0) begin
        if (t == TIMEOUT) note_timeout("a free load id");
        t++;
        @(negedge clk_i);
      end
    end
    if (timed_out) return;
    req_v_i    = 1'b1;
    req_x_i    = x;
    req_y_i    = y;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = data;
    req_id_i   = load_id_t'(id);
    t = 0;
    #1;
    while (!req_ready_o && !timed_out) begin
      if (t == TIMEOUT) note_timeout("req_ready_o");
      t++;
      @(negedge clk_i);
      #1;
    end
    if (!timed_out) expect_resp(x, y, op, addr, data, load_id_t'(id));
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors0   = errors;
    checks0   = checks;
    resp_cnt0 = resp_cnt;
  endtask

  task automatic end_test(input int n_resp);
    int t;
    t = 0;
    while (any_busy() && !timed_out) begin
      if (t == TIMEOUT) note_timeout("outstanding responses");
      t++;
      @(negedge clk_i);
    end
    check_value("response count", n_resp, resp_cnt - resp_cnt0);
    check_value("unforwarded cache requests", 0, fwd_q[0].size() + fwd_q[1].size());
    tests++;
    $display("test %s: %0d checks, %0d errors", test_name, checks - checks0, errors - errors0);
  endtask

  // loader response side
  initial begin : resp_monitor
    load_id_t id;
    resp_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rand_stall) begin
        resp_ready_i = (($random(seed) & 3) != 0);
      end else begin
        resp_ready_i = !hold_resp;
      end
      #1;
      if (resp_v_o && resp_ready_i) begin
        id = resp_id_o;
        checks++;
        assert (busy[id]) else begin
          $display("test %s: response with id %0d but no such request in flight", test_name, id);
          errors++;
        end
        check_value("data", exp_data[id], resp_data_o);
        check_value("err", exp_err[id], resp_err_o);
        busy[id] = 1'b0;
        resp_cnt++;
      end
    end
  end

  for (genvar p = 0; p < NUM_CACHE; p++) begin : g_cache
    logic     req_ready;
    logic     resp_v;
    data_t    resp_data;
    load_id_t resp_id;
    data_t    mem [MEM_WORDS];

    assign cache_req_ready_i[p] = req_ready;
    assign cache_resp_v_i[p]    = resp_v;
    assign cache_resp_data_i[p] = resp_data;
    assign cache_resp_id_i[p]   = resp_id;

    initial begin : model
      mc_op_e   c_op;
      addr_t    c_addr;
      data_t    c_data;
      load_id_t c_id;
      int       wait_cycles;
      int       t;
      req_ready = 1'b0;
      resp_v    = 1'b0;
      resp_data = '0;
      resp_id   = '0;
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] = '0;
      end
      forever begin
        @(negedge clk_i);
        resp_v    = 1'b0;
        req_ready = 1'b1;
        #1;
        if (cache_req_v_o[p]) begin
          c_op   = cache_req_op_o;
          c_addr = cache_req_addr_o;
          c_data = cache_req_data_o;
          c_id   = cache_req_id_o;
          @(negedge clk_i);
          req_ready = 1'b0;
          if (fwd_q[p].size() == 0) begin
            $display("test %s: cache port %0d got a request meant elsewhere", test_name, p);
            errors++;
          end else begin
            check_value("cache request", fwd_q[p].pop_front(), {c_op, c_addr, c_data, c_id});
          end
          if (c_op == OP_STORE) begin
            mem[c_addr] = c_data;
            resp_data   = '0;
          end else begin
            resp_data = mem[c_addr];
          end
          resp_id     = c_id;
          wait_cycles = {$random(seed)} % 4;
          repeat (wait_cycles) @(negedge clk_i);
          resp_v = 1'b1;
          t = 0;
          #1;
          while (!cache_resp_ready_o[p] && !timed_out) begin
            if (t == TIMEOUT) note_timeout("cache_resp_ready_o");
            t++;
            @(negedge clk_i);
            #1;
          end
          @(posedge clk_i);
        end
      end
    end
  end

  task automatic test_tile();
    start_test("tile");
    send_req(2'd0, TILE_Y, OP_STORE, 4'd3, 32'h1111_0003);
    send_req(2'd1, TILE_Y, OP_STORE, 4'd3, 32'h2222_0003);
    send_req(2'd0, TILE_Y, OP_STORE, 4'd9, 32'h1111_0009);
    send_req(2'd0, TILE_Y, OP_LOAD, 4'd3, '0);
    send_req(2'd1, TILE_Y, OP_LOAD, 4'd3, '0);
    send_req(2'd0, TILE_Y, OP_LOAD, 4'd9, '0);
    // never written
    send_req(2'd1, TILE_Y, OP_LOAD, 4'd9, '0);
    end_test(7);
  endtask

  task automatic test_cache();
    start_test("cache");
    send_req(2'd0, CACHE_Y, OP_STORE, 4'd5, 32'hc0c0_0005);
    send_req(2'd1, CACHE_Y, OP_STORE, 4'd5, 32'hc1c1_0005);
    send_req(2'd0, CACHE_Y, OP_LOAD, 4'd5, '0);
    send_req(2'd1, CACHE_Y, OP_LOAD, 4'd5, '0);
    send_req(2'd1, CACHE_Y, OP_LOAD, 4'd2, '0);
    end_test(5);
  endtask

  task automatic test_stray();
    start_test("stray");
    send_req(2'd2, TILE_Y, OP_STORE, 4'd1, 32'hdead_0001);
    send_req(2'd3, TILE_Y, OP_LOAD, 4'd1, '0);
    send_req(2'd2, CACHE_Y, OP_LOAD, 4'd4, '0);
    send_req(2'd3, CACHE_Y, OP_STORE, 4'd4, 32'hdead_0004);
    end_test(4);
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    hold_resp = 1'b1;
    // one request parked at each endpoint
    send_req(2'd0, TILE_Y, OP_STORE, 4'd12, 32'h0bad_f00d);
    send_req(2'd1, TILE_Y, OP_LOAD, 4'd3, '0);
    send_req(2'd1, CACHE_Y, OP_LOAD, 4'd5, '0);
    send_req(2'd3, TILE_Y, OP_LOAD, 4'd0, '0);
    @(negedge clk_i);
    req_v_i    = 1'b1;
    req_x_i    = 2'd0;
    req_y_i    = CACHE_Y;
    req_op_i   = OP_LOAD;
    req_addr_i = 4'd1;
    req_id_i   = '0;
    repeat (6) begin
      #1;
      checks++;
      assert (!req_ready_o) else begin
        $display("test %s: req_ready_o high with every credit outstanding", test_name);
        errors++;
      end
      @(negedge clk_i);
    end
    req_v_i   = 1'b0;
    hold_resp = 1'b0;
    send_req(2'd0, CACHE_Y, OP_LOAD, 4'd1, '0);
    end_test(5);
  endtask

  task automatic test_mixed();
    x_cord_t rx;
    y_cord_t ry;
    mc_op_e  rop;
    addr_t   raddr;
    data_t   rdata;
    start_test("mixed");
    rand_stall = 1'b1;
    for (int n = 0; n < 40; n++) begin
      rx    = x_cord_t'($random(seed));
      ry    = y_cord_t'($random(seed));
      rop   = mc_op_e'($random(seed) & 1);
      // small address range so loads hit earlier stores
      raddr = addr_t'($random(seed) & 3);
      rdata = $random(seed);
      send_req(rx, ry, rop, raddr, rdata);
    end
    end_test(40);
    rand_stall = 1'b0;
  endtask

  initial begin : main
    seed       = 28896;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    resp_cnt   = 0;
    hold_resp  = 1'b0;
    rand_stall = 1'b0;
    timed_out  = 1'b0;
    test_name  = "reset";
    arst_n_i   = 1'b0;
    req_v_i    = 1'b0;
    req_x_i    = '0;
    req_y_i    = '0;
    req_op_i   = OP_STORE;
    req_addr_i = '0;
    req_data_i = '0;
    req_id_i   = '0;
    for (int i = 0; i < NUM_IDS; i++) begin
      busy[i] = 1'b0;
    end
    foreach (ref_mem[i, j, k]) begin
      ref_mem[i][j][k] = '0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    test_tile();
    test_cache();
    test_stray();
    test_backpressure();
    test_mixed();

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, u_dut.u_chk.fail_cnt);
    if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hw/mc_pkg.sv
hw/mc_router.sv
hw/mc_tile.sv
hw/mc_link_tieoff.sv
hw/mc_credit_counter.sv
hw/mc_resp_arbiter.sv
hw/mc_wrapper.sv
verification/mc_wrapper_chk.sv
verification/mc_tb.sv
